// File: Bender.yml
package:
  name: sprite_table

sources:
  - include_dirs:
      - .
    files:
      - sprite_table_pkg.sv
      - sprite_reg_bank.sv
      - sprite_hit_search.sv
      - sprite_table.sv
      - target: test
        files:
          - tb_sprite_table.sv

// File: sprite_hit_search.sv
// pixel hit search over the sprite table with a one-deep registered result stage
module sprite_hit_search (
	input  logic                           clk,
	input  logic                           reset,      // sync, active low
	input  sprite_table_pkg::entry_array_t entries,    // live table from the bank
	input  logic                           q_valid,    // query present
	input  sprite_table_pkg::pixel_t       q_pixel,    // column and row to test
	output logic                           q_ready,    // result slot free or draining
	output logic                           res_valid,  // result held
	output sprite_table_pkg::hit_t         res,        // hit flag, slot, entry
	input  logic                           res_ready   // consumer takes result
);

	import sprite_table_pkg::*;

	logic [num_sprites-1:0] match;                  // per-entry cover flags
	hit_t                   hit_d;                  // combinational answer
	logic                   q_fire;                 // query accepted this cycle

	////////////////////////////////////////////////////////////////////////////
	// per-entry span compare
	////////////////////////////////////////////////////////////////////////////

	// one extra bit on the bottom limit so row + 19 near the screen end
	// does not wrap back to the top
	always_comb begin
		logic [coord_w:0] row_lim;                  // first row below the sprite
		for (int i = 0; i < num_sprites; i++) begin
			row_lim  = (coord_w+1)'(entries[i].row) + (coord_w+1)'(sprite_height);
			match[i] = (q_pixel.col == entries[i].col)            // same column
				&& (q_pixel.row >= entries[i].row)                // at or under top
				&& ((coord_w+1)'(q_pixel.row) < row_lim);         // above bottom
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// priority select
	////////////////////////////////////////////////////////////////////////////

	// scan upward, later matches overwrite, so the highest slot wins
	always_comb begin
		hit_d = '0;                                 // miss gives all zero
		for (int i = 0; i < num_sprites; i++) begin
			if (match[i]) begin
				hit_d.hit   = 1'b1;
				hit_d.slot  = slot_w'(i);
				hit_d.entry = entries[i];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// result stage and handshake
	////////////////////////////////////////////////////////////////////////////

	assign q_ready = !res_valid || res_ready;       // free, or emptied this cycle
	assign q_fire  = q_valid && q_ready;

	always_ff @(posedge clk) begin
		if (!reset) begin
			res_valid <= 1'b0;
		end else if (q_ready) begin
			res_valid <= q_valid;                   // refill or go empty
		end
	end

	// payload loads only on acceptance, held under back-pressure
	always_ff @(posedge clk) begin
		if (q_fire) begin
			res <= hit_d;                           // table as of acceptance cycle
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// a stalled result stays put until taken
	a_res_hold: assert property (
		@(posedge clk) disable iff (!reset)
		(res_valid && !res_ready) |=> (res_valid && $stable(res))
	);

endmodule

// File: sprite_reg_bank.sv
// sprite entry registers with field-selective write decode and write acknowledge
module sprite_reg_bank (
	input  logic                           clk,
	input  logic                           reset,      // sync, active low
	input  logic                           wr_valid,   // write request present
	input  sprite_table_pkg::sprite_wr_t   wr,         // slot, field code, new values
	output logic                           wr_ready,   // always accepting
	output logic                           wr_ack,     // one pulse per applied write
	output sprite_table_pkg::entry_array_t entries     // live table contents
);

	import sprite_table_pkg::*;

	logic wr_fire;                                  // write accepted this cycle
	logic field_known;                              // code maps to a real field

	////////////////////////////////////////////////////////////////////////////
	// handshake and decode
	////////////////////////////////////////////////////////////////////////////

	assign wr_ready = 1'b1;                         // one write per cycle, no stall
	assign wr_fire  = wr_valid && wr_ready;

	always_comb begin
		case (wr.field)
			field_pos:    field_known = 1'b1;       // column and row
			field_offset: field_known = 1'b1;       // offset
			default:      field_known = 1'b0;       // accepted, no effect
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// entry registers
	////////////////////////////////////////////////////////////////////////////

	// new contents show up to the search from the next cycle on
	always_ff @(posedge clk) begin
		if (!reset) begin
			entries <= '0;                          // every sprite at 0,0, offset 0
			wr_ack  <= 1'b0;
		end else begin
			wr_ack <= wr_fire && field_known;       // registered, one cycle late
			if (wr_fire) begin
				case (wr.field)
					field_pos: begin
						entries[wr.slot].col <= wr.data.col;    // offset kept
						entries[wr.slot].row <= wr.data.row;
					end
					field_offset: begin
						entries[wr.slot].offset <= wr.data.offset; // position kept
					end
					default: ;                      // unknown code, table untouched
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	// ack only follows an accepted write with a real field code
	a_ack_after_write: assert property (
		@(posedge clk) disable iff (!reset)
		wr_ack |-> $past(wr_valid && wr_ready && (wr.field inside {field_pos, field_offset}))
	);

endmodule

// File: sprite_table.f
+incdir+.
sprite_table_pkg.sv
sprite_reg_bank.sv
sprite_hit_search.sv
sprite_table.sv
tb_sprite_table.sv

// File: sprite_table.sv
// sprite attribute table top, joins the register bank to the hit search
module sprite_table (
	input  logic                         clk,
	input  logic                         reset,      // sync, active low
	// write channel
	input  logic                         wr_valid,
	input  sprite_table_pkg::sprite_wr_t wr,
	output logic                         wr_ready,
	output logic                         wr_ack,
	// query channel
	input  logic                         q_valid,
	input  sprite_table_pkg::pixel_t     q_pixel,
	output logic                         q_ready,
	// result channel
	output logic                         res_valid,
	output sprite_table_pkg::hit_t       res,
	input  logic                         res_ready
);

	import sprite_table_pkg::*;

	entry_array_t entries;                          // bank to search, no delay

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	sprite_reg_bank u_bank (
		.clk      (clk),
		.reset    (reset),
		.wr_valid (wr_valid),
		.wr       (wr),
		.wr_ready (wr_ready),
		.wr_ack   (wr_ack),
		.entries  (entries)
	);

	////////////////////////////////////////////////////////////////////////////
	// search
	////////////////////////////////////////////////////////////////////////////

	sprite_hit_search u_search (
		.clk       (clk),
		.reset     (reset),
		.entries   (entries),
		.q_valid   (q_valid),
		.q_pixel   (q_pixel),
		.q_ready   (q_ready),
		.res_valid (res_valid),
		.res       (res),
		.res_ready (res_ready)
	);

endmodule

// File: sprite_table_pkg.sv
// shared types and sizes for the sprite attribute table, imported by the RTL and the testbench
package sprite_table_pkg;

	////////////////////////////////////////////////////////////////////////////
	// table geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int num_sprites   = 32;              // entries in the table
	localparam int slot_w        = 5;               // index of one entry
	localparam int coord_w       = 10;              // column and row width
	localparam int offset_w      = 9;               // pattern offset into tile memory
	localparam int sprite_height = 20;              // rows covered, top row .. top row + 19

	////////////////////////////////////////////////////////////////////////////
	// write field codes
	////////////////////////////////////////////////////////////////////////////

	// only two codes touch the table, the other 14 are accepted and ignored
	typedef enum logic [3:0] {
		field_pos    = 4'd0,                        // column and row
		field_offset = 4'd2                         // pattern offset only
	} sprite_field_e;

	////////////////////////////////////////////////////////////////////////////
	// entry and port payloads
	////////////////////////////////////////////////////////////////////////////

	// one table entry, column in the top bits as on the bus
	typedef struct packed {
		logic [coord_w-1:0]  col;                   // screen column
		logic [coord_w-1:0]  row;                   // top row of the sprite
		logic [offset_w-1:0] offset;                // pattern offset
	} sprite_entry_t;                               // 29 bits

	// write request
	typedef struct packed {
		logic [slot_w-1:0] slot;                    // entry to update
		sprite_field_e     field;                   // which fields to take
		sprite_entry_t     data;                    // new values, unused fields ignored
	} sprite_wr_t;                                  // 38 bits

	// pixel under test
	typedef struct packed {
		logic [coord_w-1:0] col;                    // query column
		logic [coord_w-1:0] row;                    // query row
	} pixel_t;                                      // 20 bits

	// query answer
	typedef struct packed {
		logic              hit;                     // some entry covers the pixel
		logic [slot_w-1:0] slot;                    // winning entry, zero on miss
		sprite_entry_t     entry;                   // its contents, zero on miss
	} hit_t;                                        // 35 bits

	// whole table as seen by the search logic
	typedef sprite_entry_t [num_sprites-1:0] entry_array_t;

endpackage

// File: tb_sprite_model.svh
// shadow sprite table and reference hit search, included into the testbench module body
`ifndef TB_SPRITE_MODEL_SVH
`define TB_SPRITE_MODEL_SVH

sprite_entry_t shadow [num_sprites];                // expected table contents

// back to the reset state, every sprite at column 0 row 0
task automatic model_reset();
	for (int s = 0; s < num_sprites; s++) begin
		shadow[s] = '0;
	end
endtask

// apply one accepted write, tells whether an ack is owed
task automatic model_write(input sprite_wr_t w, output bit applied);
	applied = 1'b0;
	if (w.field == field_pos) begin
		shadow[w.slot].col = w.data.col;            // position only
		shadow[w.slot].row = w.data.row;
		applied = 1'b1;
	end else if (w.field == field_offset) begin
		shadow[w.slot].offset = w.data.offset;      // offset only
		applied = 1'b1;
	end
endtask

// expected answer, first covering slot found scanning from 31 down
function automatic hit_t expected_hit(input pixel_t p);
	hit_t r;
	int   top;
	int   bottom;
	r = '0;                                         // miss is all zero
	for (int s = num_sprites - 1; s >= 0; s--) begin
		top    = int'(shadow[s].row);
		bottom = top + sprite_height - 1;           // last covered row, may pass 1023
		if (!r.hit && p.col == shadow[s].col
				&& int'(p.row) >= top && int'(p.row) <= bottom) begin
			r.hit   = 1'b1;
			r.slot  = slot_w'(s);
			r.entry = shadow[s];
		end
	end
	return r;
endfunction

`endif

// File: tb_sprite_table.sv
// testbench for the sprite attribute table, simulate with tb_sprite_table as top
module tb_sprite_table;

	import sprite_table_pkg::*;

	localparam int reset_cycles    = 10;
	localparam int directed_cycles = 60;            // tests 1 to 4
	localparam int rand_cycles     = 400;
	localparam int planned_cycles  = reset_cycles + directed_cycles + rand_cycles + 20;
	localparam int timeout_cycles  = planned_cycles * 3 / 2;

	logic       clk = 1'b0;
	logic       reset;
	logic       wr_valid;
	sprite_wr_t wr;
	logic       wr_ready;
	logic       wr_ack;
	logic       q_valid;
	pixel_t     q_pixel;
	logic       q_ready;
	logic       res_valid;
	hit_t       res;
	logic       res_ready;

	integer seed           = 28;
	string  test_name      = "none";
	int     mismatch_count = 0;
	int     proto_count    = 0;                     // missing or extra handshakes
	int     checked_count  = 0;
	int     cycle_count    = 0;
	bit     ack_due        = 1'b0;                  // write applied last cycle
	bit     query_fired    = 1'b0;
	bit     res_stalled    = 1'b0;
	hit_t   held_res;
	hit_t   exp_q[$];                               // expected results in order
	string  name_q[$];                              // test owning each one

	`include "tb_sprite_model.svh"

	sprite_table u_dut (
		.clk       (clk),
		.reset     (reset),
		.wr_valid  (wr_valid),
		.wr        (wr),
		.wr_ready  (wr_ready),
		.wr_ack    (wr_ack),
		.q_valid   (q_valid),
		.q_pixel   (q_pixel),
		.q_ready   (q_ready),
		.res_valid (res_valid),
		.res       (res),
		.res_ready (res_ready)
	);

	always #50 clk = ~clk;                          // period 100

	////////////////////////////////////////////////////////////////////////////
	// scoreboard and compare
	////////////////////////////////////////////////////////////////////////////

	// expectation taken before the write of the same cycle lands
	always @(posedge clk) begin
		bit applied;
		if (reset) begin
			assert (wr_ack == ack_due) else begin
				proto_count++;
				if (ack_due) $display("missing write acknowledge in test %s", test_name);
				else $display("write acknowledge without an applied write in %s", test_name);
			end
			if (q_valid && q_ready) begin
				exp_q.push_back(expected_hit(q_pixel));
				name_q.push_back(test_name);
			end
			applied = 1'b0;
			if (wr_valid && wr_ready) model_write(wr, applied);
			ack_due = applied;
		end
	end

	always @(posedge clk) begin
		hit_t  want;
		string name;
		if (reset) begin
			if (query_fired) begin
				assert (res_valid) else begin
					proto_count++;
					$display("no result one cycle after an accepted query");
				end
			end
			if (res_stalled) begin
				assert (res_valid && res == held_res) else begin
					proto_count++;
					$display("held result changed or dropped under back-pressure");
				end
			end
			// query side closed only while a result waits untaken
			if (res_valid && !res_ready) begin
				assert (!q_ready) else begin
					proto_count++;
					$display("query channel open while a result is stalled in %s", test_name);
				end
			end else begin
				assert (q_ready) else begin
					proto_count++;
					$display("query channel stalled with the result stage free in %s",
						test_name);
				end
			end
			if (res_valid && res_ready) begin
				if (exp_q.size() == 0) begin
					proto_count++;
					$display("result delivered with no query outstanding");
				end else begin
					want = exp_q.pop_front();
					name = name_q.pop_front();
					checked_count++;
					assert (res == want) else begin
						mismatch_count++;
						$display("MISMATCH test=%s expected=%h actual=%h", name, want, res);
					end
				end
			end
			query_fired = q_valid && q_ready;
			res_stalled = res_valid && !res_ready;
			held_res    = res;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout, run still busy after %0d cycles", cycle_count);
			$display("errors: %0d mismatch, %0d protocol, %0d results checked",
				mismatch_count, proto_count, checked_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers, all enter and leave 10 units after a rising edge
	////////////////////////////////////////////////////////////////////////////

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic write_entry(input int slot, input sprite_field_e field,
			input int col, input int row, input int offset);
		wr.slot        = slot_w'(slot);
		wr.field       = field;
		wr.data.col    = coord_w'(col);
		wr.data.row    = coord_w'(row);
		wr.data.offset = offset_w'(offset);
		wr_valid       = 1'b1;
		@(posedge clk);
		while (!wr_ready) @(posedge clk);           // wait for acceptance
		#10;
		wr_valid = 1'b0;
	endtask

	task automatic run_query(input int col, input int row);
		q_pixel.col = coord_w'(col);
		q_pixel.row = coord_w'(row);
		q_valid     = 1'b1;
		@(posedge clk);
		while (!q_ready) @(posedge clk);
		#10;
		q_valid = 1'b0;
	endtask

	// until every expected result is taken, plus the last ack check
	task automatic wait_drained();
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#10;
		end
		repeat (2) begin
			@(posedge clk);
			#10;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////

	initial begin
		bit q_taken;
		reset     = 1'b0;
		wr_valid  = 1'b0;
		wr        = '0;
		q_valid   = 1'b0;
		q_pixel   = '0;
		res_ready = 1'b1;
		model_reset();
		repeat (reset_cycles) @(posedge clk);
		#10;
		reset = 1'b1;

		test_name = "reset_contents";
		assert (wr_ready && q_ready && !wr_ack && !res_valid) else begin
			mismatch_count++;
			$display("MISMATCH test=%s expected=%b actual=%b", test_name, 4'b1100,
				{wr_ready, q_ready, wr_ack, res_valid});
		end
		run_query(0, 5);                            // every slot covers, 31 wins
		run_query(0, 20);                           // one past the span
		wait_drained();

		test_name = "field_writes";
		write_entry(3, field_pos, 100, 200, 9'h0ff);        // offset ignored
		run_query(100, 205);
		write_entry(3, field_offset, 7, 7, 9'h1a5);         // position ignored
		run_query(100, 210);
		write_entry(3, field_pos, 300, 50, 9'h0ff);
		run_query(300, 50);
		run_query(100, 205);                        // old place now empty
		wait_drained();

		test_name = "unknown_fields";
		for (int code = 1; code < 16; code++) begin
			if (code != 2) write_entry(3, sprite_field_e'(code), code, code, code);
		end
		run_query(300, 50);
		run_query(1, 1);
		wait_drained();

		test_name = "span_priority";
		write_entry(5, field_pos, 400, 100, 0);
		write_entry(9, field_pos, 400, 110, 0);
		write_entry(12, field_pos, 600, 1015, 0);   // span runs off the screen
		run_query(400, 100);                        // top row
		run_query(400, 109);
		run_query(400, 119);                        // overlap, slot 9 wins
		run_query(400, 129);                        // top + 19
		run_query(400, 130);                        // top + 20
		run_query(600, 1023);
		run_query(600, 5);                          // no wrap to the top
		wait_drained();

		test_name = "random_traffic";
		for (int c = 0; c < rand_cycles; c++) begin
			@(posedge clk);
			q_taken = q_valid && q_ready;
			#10;
			wr_valid       = rand_below(2) == 1;
			wr.slot        = slot_w'(rand_below(num_sprites));
			wr.field       = (rand_below(4) == 0) ? sprite_field_e'(4'(rand_below(16)))
				: ((rand_below(2) == 1) ? field_offset : field_pos);
			wr.data.col    = coord_w'(rand_below(6));          // few columns, many hits
			wr.data.row    = coord_w'(rand_below(100));
			wr.data.offset = offset_w'(rand_below(512));
			if (q_taken || !q_valid) begin                     // hold until accepted
				q_valid     = rand_below(3) != 0;
				q_pixel.col = coord_w'(rand_below(6));
				q_pixel.row = coord_w'(rand_below(130));
			end
			res_ready = rand_below(3) != 0;
		end
		wr_valid  = 1'b0;
		res_ready = 1'b1;
		while (q_valid) begin
			@(posedge clk);
			q_taken = q_ready;
			#10;
			if (q_taken) q_valid = 1'b0;
		end
		wait_drained();

		$display("errors: %0d mismatch, %0d protocol, %0d results checked",
			mismatch_count, proto_count, checked_count);
		if (mismatch_count == 0 && proto_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule
